// ==== common/radio_ctrl_config.svh ====
/* Register map, bus widths and reset values of the dsp_clk control slice.
   Included by the package and by every block that decodes a settings or readback address */
`ifndef RADIO_CTRL_CONFIG_SVH
`define RADIO_CTRL_CONFIG_SVH

// Settings bus shape
`define RC_SET_ADDR_W 8
`define RC_SET_DATA_W 32

//////////////////////////////
// Settings register bases
//////////////////////////////
`define RC_SR_MISC 0
`define RC_SR_TIME64 10

// Offsets inside the misc bank
`define RC_MISC_SERDES 1
`define RC_MISC_ADC 2
`define RC_MISC_LED_SW 3
`define RC_MISC_PHY 4
`define RC_MISC_LED_SRC 6

// Offsets inside the time bank
`define RC_TIME_HI 0
`define RC_TIME_LO 1
`define RC_TIME_CTRL 2

// LEDs 1 to 4 start under hardware control
`define RC_LED_SRC_RESET 8'h1E

// Major 9, minor 0
`define RC_COMPAT_NUM 32'h0009_0000

//////////////////////////////
// Readback words
//////////////////////////////
`define RC_RB_ADDR_W 4
`define RC_RB_COMPAT 0
`define RC_RB_TIME_HI 1
`define RC_RB_TIME_LO 2
`define RC_RB_PPS_HI 3
`define RC_RB_PPS_LO 4
`define RC_RB_STATUS 5
`define RC_RB_LEDS 6

`endif

// ==== common/radio_ctrl_pkg.sv ====
/* Types shared by the control slice blocks and the testbench.
   Referenced by scoped name, never imported */
`default_nettype none

`include "radio_ctrl_config.svh"

package radio_ctrl_pkg;

   // One write per strobe, already in the dsp_clk domain
   typedef struct packed {
      logic                      stb;
      logic [`RC_SET_ADDR_W-1:0] addr;
      logic [`RC_SET_DATA_W-1:0] data;
   } set_bus_t;

   // Order matches the low bits of the settings word
   typedef struct packed {
      logic enable;
      logic prbsen;
      logic loopen;
      logic rx_en;
   } serdes_ctrl_t;

   typedef struct packed {
      logic oe_a;
      logic on_a;
      logic oe_b;
      logic on_b;
   } adc_ctrl_t;

   // Seconds in the upper word, ticks in the lower
   typedef struct packed {
      logic [31:0] secs_hi;
      logic [31:0] ticks_lo;
   } vita_time_t;

   typedef struct packed {
      logic       button;
      logic       clk_status;
      logic       serdes_link_up;
      logic       good_sync;
      logic [3:0] reserved;
   } status_t;

   // Time load state
   typedef enum logic [1:0] {
      LOAD_IDLE      = 2'd0,
      LOAD_ARMED_PPS = 2'd1
   } time_load_e;

endpackage

`default_nettype wire

// ==== source/control_regs.sv ====
/* Misc settings registers for SERDES, ADC, PHY reset and LEDs, with the LED source mixing.
   Sits on the dsp_clk settings bus next to the timekeeper */
`default_nettype none

`include "radio_ctrl_config.svh"

module control_regs (
   input  wire logic                          dsp_clk,
   input  wire logic                          por_rst,
   input  wire radio_ctrl_pkg::set_bus_t      set_i,
   input  wire logic                          run_rx_i,
   input  wire logic                          run_tx_i,
   input  wire logic                          clk_status_i,
   input  wire logic                          good_sync_i,
   output radio_ctrl_pkg::serdes_ctrl_t       serdes_ctrl_o,
   output radio_ctrl_pkg::adc_ctrl_t          adc_ctrl_o,
   output logic                               phy_resetn_o,
   output logic [7:0]                         leds_o,
   output logic [15:0]                        led_readback_o
);

   localparam int AW = `RC_SET_ADDR_W;

   localparam logic [AW-1:0] ADDR_SERDES  = AW'(`RC_SR_MISC + `RC_MISC_SERDES);
   localparam logic [AW-1:0] ADDR_ADC     = AW'(`RC_SR_MISC + `RC_MISC_ADC);
   localparam logic [AW-1:0] ADDR_LED_SW  = AW'(`RC_SR_MISC + `RC_MISC_LED_SW);
   localparam logic [AW-1:0] ADDR_PHY     = AW'(`RC_SR_MISC + `RC_MISC_PHY);
   localparam logic [AW-1:0] ADDR_LED_SRC = AW'(`RC_SR_MISC + `RC_MISC_LED_SRC);

   localparam int SERDES_W = $bits(radio_ctrl_pkg::serdes_ctrl_t);
   localparam int ADC_W    = $bits(radio_ctrl_pkg::adc_ctrl_t);

   logic wr_serdes;
   logic wr_adc;
   logic wr_led_sw;
   logic wr_phy;
   logic wr_led_src;

   radio_ctrl_pkg::serdes_ctrl_t serdes_q;
   radio_ctrl_pkg::adc_ctrl_t    adc_q;
   logic                         phy_reset_q;
   logic [7:0]                   led_sw_q;
   logic [7:0]                   led_src_q;
   logic [7:0]                   led_hw;

   //////////////////////////////
   // Address decode
   //////////////////////////////
   assign wr_serdes  = set_i.stb && (set_i.addr == ADDR_SERDES);
   assign wr_adc     = set_i.stb && (set_i.addr == ADDR_ADC);
   assign wr_led_sw  = set_i.stb && (set_i.addr == ADDR_LED_SW);
   assign wr_phy     = set_i.stb && (set_i.addr == ADDR_PHY);
   assign wr_led_src = set_i.stb && (set_i.addr == ADDR_LED_SRC);

   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         serdes_q    <= '0;
         adc_q       <= '0;
         phy_reset_q <= 1'b0;
         led_sw_q    <= '0;
         led_src_q   <= `RC_LED_SRC_RESET;
      end else begin
         if (wr_serdes) begin
            serdes_q <= radio_ctrl_pkg::serdes_ctrl_t'(set_i.data[SERDES_W-1:0]);
         end
         if (wr_adc) begin
            adc_q <= radio_ctrl_pkg::adc_ctrl_t'(set_i.data[ADC_W-1:0]);
         end
         if (wr_led_sw) begin
            led_sw_q <= set_i.data[7:0];
         end
         if (wr_phy) begin
            phy_reset_q <= set_i.data[0];
         end
         if (wr_led_src) begin
            led_src_q <= set_i.data[7:0];
         end
      end
   end

   assign serdes_ctrl_o = serdes_q;
   assign adc_ctrl_o    = adc_q;

   // PHY pin is active low
   assign phy_resetn_o = ~phy_reset_q;

   //////////////////////////////
   // LED mixing
   //////////////////////////////
   // Mask bit set selects the hardware source
   assign led_hw = {3'b000, run_tx_i, run_rx_i, clk_status_i, good_sync_i, 1'b0};
   assign leds_o = (led_src_q & led_hw) | (~led_src_q & led_sw_q);

   assign led_readback_o = {led_src_q, led_sw_q};

endmodule

`default_nettype wire

// ==== timekeeper/vita_time.sv ====
/* 64-bit VITA timekeeper, loaded at once or at the next PPS edge, latching the time on PPS.
   Written through the time bank of the settings bus */
`default_nettype none

`include "radio_ctrl_config.svh"

module vita_time (
   input  wire logic                       dsp_clk,
   input  wire logic                       por_rst,
   input  wire radio_ctrl_pkg::set_bus_t   set_i,
   input  wire logic                       pps_i,
   output radio_ctrl_pkg::vita_time_t      vita_time_o,
   output radio_ctrl_pkg::vita_time_t      vita_time_pps_o,
   output logic                            pps_int_o,
   output logic                            good_sync_o
);

   localparam int AW = `RC_SET_ADDR_W;

   localparam logic [AW-1:0] ADDR_HI   = AW'(`RC_SR_TIME64 + `RC_TIME_HI);
   localparam logic [AW-1:0] ADDR_LO   = AW'(`RC_SR_TIME64 + `RC_TIME_LO);
   localparam logic [AW-1:0] ADDR_CTRL = AW'(`RC_SR_TIME64 + `RC_TIME_CTRL);

   logic [`RC_SET_DATA_W-1:0]  pend_hi;
   logic [`RC_SET_DATA_W-1:0]  pend_lo;
   radio_ctrl_pkg::time_load_e state;
   radio_ctrl_pkg::vita_time_t time_q;
   radio_ctrl_pkg::vita_time_t load_value;

   // Two sync flops, then one more for the edge detector
   logic [2:0] pps_sync;
   logic       pps_edge;

   logic wr_hi;
   logic wr_lo;
   logic wr_ctrl;
   logic load_now;
   logic load_pps;
   logic time_load;

   assign wr_hi   = set_i.stb && (set_i.addr == ADDR_HI);
   assign wr_lo   = set_i.stb && (set_i.addr == ADDR_LO);
   assign wr_ctrl = set_i.stb && (set_i.addr == ADDR_CTRL);

   // Pending time words
   always_ff @(posedge dsp_clk) begin
      if (wr_hi) begin
         pend_hi <= set_i.data;
      end
      if (wr_lo) begin
         pend_lo <= set_i.data;
      end
   end

   //////////////////////////////
   // PPS synchronizer
   //////////////////////////////
   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         pps_sync <= '0;
      end else begin
         pps_sync <= {pps_sync[1:0], pps_i};
      end
   end

   assign pps_edge = pps_sync[1] & ~pps_sync[2];

   //////////////////////////////
   // Load control
   //////////////////////////////
   assign load_now   = wr_ctrl & ~set_i.data[0];
   assign load_pps   = pps_edge & (state == radio_ctrl_pkg::LOAD_ARMED_PPS);
   assign time_load  = load_now | load_pps;
   assign load_value = {pend_hi, pend_lo};

   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         state <= radio_ctrl_pkg::LOAD_IDLE;
      end else begin
         case (state)
            radio_ctrl_pkg::LOAD_IDLE: begin
               if (wr_ctrl && set_i.data[0]) begin
                  state <= radio_ctrl_pkg::LOAD_ARMED_PPS;
               end
            end
            radio_ctrl_pkg::LOAD_ARMED_PPS: begin
               // An immediate load drops the pending arm
               if (pps_edge || load_now) begin
                  state <= radio_ctrl_pkg::LOAD_IDLE;
               end
            end
            default: state <= radio_ctrl_pkg::LOAD_IDLE;
         endcase
      end
   end

   // Time counter and PPS latch
   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         time_q          <= '0;
         vita_time_pps_o <= '0;
         pps_int_o       <= 1'b0;
         good_sync_o     <= 1'b0;
      end else begin
         if (time_load) begin
            time_q <= load_value;
         end else begin
            time_q <= radio_ctrl_pkg::vita_time_t'(time_q + 64'd1);
         end
         // Latch sees the time from before any load at this edge
         if (pps_edge) begin
            vita_time_pps_o <= time_q;
         end
         pps_int_o <= pps_edge;
         if (load_pps) begin
            good_sync_o <= 1'b1;
         end
      end
   end

   assign vita_time_o = time_q;

endmodule

`default_nettype wire

// ==== source/readback_mux.sv ====
/* Registered readback of version, time, PPS time, status and LED words.
   A strobe returns its word with a one-cycle acknowledge on the next cycle */
`default_nettype none

`include "radio_ctrl_config.svh"

module readback_mux (
   input  wire logic                        dsp_clk,
   input  wire logic                        por_rst,
   input  wire logic                        rb_stb_i,
   input  wire logic [`RC_RB_ADDR_W-1:0]    rb_addr_i,
   input  wire radio_ctrl_pkg::vita_time_t  vita_time_i,
   input  wire radio_ctrl_pkg::vita_time_t  vita_time_pps_i,
   input  wire radio_ctrl_pkg::status_t     status_i,
   input  wire logic [15:0]                 led_readback_i,
   output logic [31:0]                      rb_data_o,
   output logic                             rb_ack_o
);

   localparam int RW = `RC_RB_ADDR_W;
   localparam int SW = $bits(radio_ctrl_pkg::status_t);

   logic [31:0] sel_word;

   //////////////////////////////
   // Word select
   //////////////////////////////
   always_comb begin
      case (rb_addr_i)
         RW'(`RC_RB_COMPAT):  sel_word = `RC_COMPAT_NUM;
         RW'(`RC_RB_TIME_HI): sel_word = vita_time_i.secs_hi;
         RW'(`RC_RB_TIME_LO): sel_word = vita_time_i.ticks_lo;
         RW'(`RC_RB_PPS_HI):  sel_word = vita_time_pps_i.secs_hi;
         RW'(`RC_RB_PPS_LO):  sel_word = vita_time_pps_i.ticks_lo;
         RW'(`RC_RB_STATUS):  sel_word = {{(32 - SW){1'b0}}, status_i};
         RW'(`RC_RB_LEDS):    sel_word = {16'h0000, led_readback_i};
         default:             sel_word = '0;
      endcase
   end

   // Data is captured only on a strobe
   always_ff @(posedge dsp_clk) begin
      if (rb_stb_i) begin
         rb_data_o <= sel_word;
      end
   end

   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         rb_ack_o <= 1'b0;
      end else begin
         rb_ack_o <= rb_stb_i;
      end
   end

endmodule

`default_nettype wire

// ==== source/radio_ctrl_top.sv ====
/* Top of the dsp_clk control slice, joining the misc registers, timekeeper and readback.
   The settings bus fans out to every block unchanged */
`default_nettype none

`include "radio_ctrl_config.svh"

module radio_ctrl_top (
   input  wire logic                        dsp_clk,
   input  wire logic                        por_rst,
   input  wire radio_ctrl_pkg::set_bus_t    set_i,
   input  wire logic                        pps_i,
   input  wire logic                        run_rx_i,
   input  wire logic                        run_tx_i,
   input  wire logic                        clk_status_i,
   input  wire logic                        button_i,
   input  wire logic                        serdes_link_up_i,
   input  wire logic                        rb_stb_i,
   input  wire logic [`RC_RB_ADDR_W-1:0]    rb_addr_i,
   output radio_ctrl_pkg::serdes_ctrl_t     serdes_ctrl_o,
   output radio_ctrl_pkg::adc_ctrl_t        adc_ctrl_o,
   output logic                             phy_resetn_o,
   output logic [7:0]                       leds_o,
   output radio_ctrl_pkg::vita_time_t       vita_time_o,
   output logic                             pps_int_o,
   output logic [31:0]                      rb_data_o,
   output logic                             rb_ack_o
);

   radio_ctrl_pkg::vita_time_t vita_time_pps;
   radio_ctrl_pkg::status_t    status;
   logic                       good_sync;
   logic [15:0]                led_readback;

   // Status word for readback
   assign status.button         = button_i;
   assign status.clk_status     = clk_status_i;
   assign status.serdes_link_up = serdes_link_up_i;
   assign status.good_sync      = good_sync;
   assign status.reserved       = '0;

   //////////////////////////////
   // Blocks
   //////////////////////////////
   control_regs control_regs_i (
      .dsp_clk        (dsp_clk),
      .por_rst        (por_rst),
      .set_i          (set_i),
      .run_rx_i       (run_rx_i),
      .run_tx_i       (run_tx_i),
      .clk_status_i   (clk_status_i),
      .good_sync_i    (good_sync),
      .serdes_ctrl_o  (serdes_ctrl_o),
      .adc_ctrl_o     (adc_ctrl_o),
      .phy_resetn_o   (phy_resetn_o),
      .leds_o         (leds_o),
      .led_readback_o (led_readback)
   );

   vita_time vita_time_i (
      .dsp_clk         (dsp_clk),
      .por_rst         (por_rst),
      .set_i           (set_i),
      .pps_i           (pps_i),
      .vita_time_o     (vita_time_o),
      .vita_time_pps_o (vita_time_pps),
      .pps_int_o       (pps_int_o),
      .good_sync_o     (good_sync)
   );

   readback_mux readback_mux_i (
      .dsp_clk         (dsp_clk),
      .por_rst         (por_rst),
      .rb_stb_i        (rb_stb_i),
      .rb_addr_i       (rb_addr_i),
      .vita_time_i     (vita_time_o),
      .vita_time_pps_i (vita_time_pps),
      .status_i        (status),
      .led_readback_i  (led_readback),
      .rb_data_o       (rb_data_o),
      .rb_ack_o        (rb_ack_o)
   );

endmodule

`default_nettype wire

// ==== bench/radio_ctrl_properties.sv ====
/* Concurrent checks on the control slice top, attached with bind.
   Covers readback acknowledge timing, PPS pulse width and time counting */
`default_nettype none

`include "radio_ctrl_config.svh"

module radio_ctrl_properties (
   input wire logic                       dsp_clk,
   input wire logic                       por_rst,
   input wire radio_ctrl_pkg::set_bus_t   set_i,
   input wire logic                       rb_stb_i,
   input wire logic                       rb_ack_i,
   input wire logic                       pps_int_i,
   input wire radio_ctrl_pkg::vita_time_t vita_time_i,
   input wire radio_ctrl_pkg::time_load_e load_state_i
);
   timeunit 1ns;
   timeprecision 100ps;

   localparam logic [7:0] CTRL_ADDR = 8'(`RC_SR_TIME64 + `RC_TIME_CTRL);

   int   fail_count = 0;
   logic load_now;

   assign load_now = set_i.stb && (set_i.addr == CTRL_ADDR) && !set_i.data[0];

   // Acknowledge is the strobe one cycle late
   ack_follows_stb: assert property (@(posedge dsp_clk) disable iff (por_rst)
      !por_rst |=> (rb_ack_i == $past(rb_stb_i)))
      else begin
         fail_count++;
         $error("rb_ack_o did not follow rb_stb_i by one cycle");
      end

   pps_single_cycle: assert property (@(posedge dsp_clk) disable iff (por_rst)
      (!por_rst && pps_int_i) |=> !pps_int_i)
      else begin
         fail_count++;
         $error("pps_int_o stayed high for two cycles");
      end

   // A PPS load shows up as pps_int_o after an armed cycle
   time_counts: assert property (@(posedge dsp_clk) disable iff (por_rst)
      (!por_rst && !load_now) |=>
         ((pps_int_i && $past(load_state_i) == radio_ctrl_pkg::LOAD_ARMED_PPS) ||
          (64'(vita_time_i) == 64'($past(vita_time_i)) + 64'd1)))
      else begin
         fail_count++;
         $error("vita_time_o did not count up by one");
      end

endmodule

bind radio_ctrl_top radio_ctrl_properties radio_ctrl_properties_i (
   .dsp_clk      (dsp_clk),
   .por_rst      (por_rst),
   .set_i        (set_i),
   .rb_stb_i     (rb_stb_i),
   .rb_ack_i     (rb_ack_o),
   .pps_int_i    (pps_int_o),
   .vita_time_i  (vita_time_o),
   .load_state_i (vita_time_i.state)
);

`default_nettype wire

// ==== bench/radio_ctrl_tb.sv ====
/* Directed testbench for the dsp_clk control slice.
   Drives settings writes, PPS pulses and readback strobes and checks each response */
`default_nettype none

`include "radio_ctrl_config.svh"

module radio_ctrl_tb;
   timeunit 1ns;
   timeprecision 100ps;

   localparam int TIMEOUT_CYCLES = 20;
   localparam logic [7:0] ADDR_SERDES    = 8'(`RC_SR_MISC + `RC_MISC_SERDES);
   localparam logic [7:0] ADDR_ADC       = 8'(`RC_SR_MISC + `RC_MISC_ADC);
   localparam logic [7:0] ADDR_LED_SW    = 8'(`RC_SR_MISC + `RC_MISC_LED_SW);
   localparam logic [7:0] ADDR_PHY       = 8'(`RC_SR_MISC + `RC_MISC_PHY);
   localparam logic [7:0] ADDR_LED_SRC   = 8'(`RC_SR_MISC + `RC_MISC_LED_SRC);
   localparam logic [7:0] ADDR_TIME_HI   = 8'(`RC_SR_TIME64 + `RC_TIME_HI);
   localparam logic [7:0] ADDR_TIME_LO   = 8'(`RC_SR_TIME64 + `RC_TIME_LO);
   localparam logic [7:0] ADDR_TIME_CTRL = 8'(`RC_SR_TIME64 + `RC_TIME_CTRL);

   logic                         dsp_clk;
   logic                         por_rst;
   radio_ctrl_pkg::set_bus_t     set_bus;
   logic                         pps;
   logic                         run_rx;
   logic                         run_tx;
   logic                         clk_status;
   logic                         button;
   logic                         link_up;
   logic                         rb_stb;
   logic [`RC_RB_ADDR_W-1:0]     rb_addr;
   radio_ctrl_pkg::serdes_ctrl_t serdes_ctrl;
   radio_ctrl_pkg::adc_ctrl_t    adc_ctrl;
   logic                         phy_resetn;
   logic [7:0]                   leds;
   radio_ctrl_pkg::vita_time_t   vita_time;
   logic                         pps_int;
   logic [31:0]                  rb_data;
   logic                         rb_ack;

   // Expected register contents
   logic [7:0]                   exp_led_src;
   logic [7:0]                   exp_led_sw;
   logic                         exp_good_sync;
   radio_ctrl_pkg::vita_time_t   exp_pps_time;

   radio_ctrl_top radio_ctrl_top_i (
      .dsp_clk          (dsp_clk),
      .por_rst          (por_rst),
      .set_i            (set_bus),
      .pps_i            (pps),
      .run_rx_i         (run_rx),
      .run_tx_i         (run_tx),
      .clk_status_i     (clk_status),
      .button_i         (button),
      .serdes_link_up_i (link_up),
      .rb_stb_i         (rb_stb),
      .rb_addr_i        (rb_addr),
      .serdes_ctrl_o    (serdes_ctrl),
      .adc_ctrl_o       (adc_ctrl),
      .phy_resetn_o     (phy_resetn),
      .leds_o           (leds),
      .vita_time_o      (vita_time),
      .pps_int_o        (pps_int),
      .rb_data_o        (rb_data),
      .rb_ack_o         (rb_ack)
   );

   initial begin
      dsp_clk = 1'b0;
      forever #4 dsp_clk = ~dsp_clk;
   end

   // Global cycle limit
   initial begin
      repeat (5000) @(posedge dsp_clk);
      report_failure("Simulation ran past its cycle limit");
   end

   //////////////////////////////
   // Reporting and compares
   //////////////////////////////
   task automatic report_failure(input string what);
      $display("%s", what);
      $display("Finished with errors");
      $fatal(1, "Run stopped at the first error");
   endtask

   task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp) begin
         report_failure($sformatf("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp));
      end
   endtask

   task automatic check_time(input string name, input radio_ctrl_pkg::vita_time_t got,
                             input radio_ctrl_pkg::vita_time_t exp);
      if (got !== exp) begin
         report_failure($sformatf("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp));
      end
   endtask

   task automatic check_leds(input string name, input logic [7:0] got, input logic [7:0] exp);
      if (got !== exp) begin
         report_failure($sformatf("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp));
      end
   endtask

   task automatic check_serdes(input string name, input radio_ctrl_pkg::serdes_ctrl_t got,
                               input radio_ctrl_pkg::serdes_ctrl_t exp);
      if (got !== exp) begin
         report_failure($sformatf("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp));
      end
   endtask

   task automatic check_adc(input string name, input radio_ctrl_pkg::adc_ctrl_t got,
                            input radio_ctrl_pkg::adc_ctrl_t exp);
      if (got !== exp) begin
         report_failure($sformatf("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp));
      end
   endtask

   //////////////////////////////
   // Reference model
   //////////////////////////////
   function automatic logic [7:0] predict_leds();
      logic [7:0] hw;
      hw = {3'b000, run_tx, run_rx, clk_status, exp_good_sync, 1'b0};
      return (exp_led_src & hw) | (~exp_led_src & exp_led_sw);
   endfunction

   function automatic logic [31:0] status_word();
      return {24'h0, button, clk_status, link_up, exp_good_sync, 4'h0};
   endfunction

   // Time words come from the snapshot taken before the capture edge
   function automatic logic [31:0] expected_word(input logic [3:0] addr,
                                                 input radio_ctrl_pkg::vita_time_t now);
      case (addr)
         4'd0:    return {16'd9, 16'd0};
         4'd1:    return now.secs_hi;
         4'd2:    return now.ticks_lo;
         4'd3:    return exp_pps_time.secs_hi;
         4'd4:    return exp_pps_time.ticks_lo;
         4'd5:    return status_word();
         4'd6:    return {16'h0000, exp_led_src, exp_led_sw};
         default: return 32'h0;
      endcase
   endfunction

   //////////////////////////////
   // Bus helpers
   //////////////////////////////
   task automatic write_setting(input logic [7:0] waddr, input logic [31:0] wdata);
      @(posedge dsp_clk);
      set_bus <= '{stb: 1'b1, addr: waddr, data: wdata};
      @(posedge dsp_clk);
      set_bus <= '0;
   endtask

   task automatic read_word(input logic [3:0] raddr, output logic [31:0] rdata);
      int waited;
      @(posedge dsp_clk);
      rb_stb  <= 1'b1;
      rb_addr <= raddr;
      @(posedge dsp_clk);
      rb_stb  <= 1'b0;
      waited = 0;
      @(negedge dsp_clk);
      while (!rb_ack && waited < TIMEOUT_CYCLES) begin
         @(negedge dsp_clk);
         waited++;
      end
      if (!rb_ack) begin
         report_failure($sformatf("No readback acknowledge for address %0d", raddr));
      end else begin
         rdata = rb_data;
      end
   endtask

   //////////////////////////////
   // Directed tests
   //////////////////////////////
   task automatic test_reset_values();
      logic [31:0] word;
      @(negedge dsp_clk);
      check_serdes("serdes_ctrl_o", serdes_ctrl, '0);
      check_adc("adc_ctrl_o", adc_ctrl, '0);
      check_word("phy_resetn_o", {31'd0, phy_resetn}, 32'd1);
      check_leds("leds_o", leds, predict_leds());
      read_word(4'd6, word);
      check_word("led readback word", word, 32'h0000_1E00);
      read_word(4'd0, word);
      check_word("compat word", word, {16'd9, 16'd0});
      read_word(4'd5, word);
      check_word("status word", word, status_word());
   endtask

   task automatic test_setting_regs();
      logic [31:0]                  data;
      radio_ctrl_pkg::serdes_ctrl_t exp_serdes;
      radio_ctrl_pkg::adc_ctrl_t    exp_adc;
      logic                         exp_phyn;
      repeat (4) begin
         data = $urandom();
         exp_serdes = radio_ctrl_pkg::serdes_ctrl_t'(data[3:0]);
         write_setting(ADDR_SERDES, data);
         @(negedge dsp_clk);
         check_serdes("serdes_ctrl_o", serdes_ctrl, exp_serdes);
         data = $urandom();
         exp_adc = radio_ctrl_pkg::adc_ctrl_t'(data[3:0]);
         write_setting(ADDR_ADC, data);
         @(negedge dsp_clk);
         check_adc("adc_ctrl_o", adc_ctrl, exp_adc);
         data = $urandom();
         exp_phyn = ~data[0];
         write_setting(ADDR_PHY, data);
         @(negedge dsp_clk);
         check_word("phy_resetn_o", {31'd0, phy_resetn}, {31'd0, exp_phyn});
      end
      // Holes in the misc bank
      write_setting(8'd5, $urandom());
      write_setting(8'd7, $urandom());
      @(negedge dsp_clk);
      check_serdes("serdes_ctrl_o", serdes_ctrl, exp_serdes);
      check_adc("adc_ctrl_o", adc_ctrl, exp_adc);
      check_word("phy_resetn_o", {31'd0, phy_resetn}, {31'd0, exp_phyn});
      check_leds("leds_o", leds, predict_leds());
   endtask

   task automatic test_led_mixing();
      logic [31:0] data;
      logic [31:0] word;
      repeat (8) begin
         data = $urandom();
         exp_led_sw = data[7:0];
         write_setting(ADDR_LED_SW, data);
         data = $urandom();
         exp_led_src = data[7:0];
         write_setting(ADDR_LED_SRC, data);
         data = $urandom();
         run_rx     <= data[0];
         run_tx     <= data[1];
         clk_status <= data[2];
         @(negedge dsp_clk);
         check_leds("leds_o", leds, predict_leds());
      end
      read_word(4'd6, word);
      check_word("led readback word", word, {16'h0000, exp_led_src, exp_led_sw});
   endtask

   task automatic test_time_load();
      logic [31:0] hi;
      logic [31:0] lo;
      logic [31:0] gap;
      logic [31:0] word;
      int          cycles;
      hi  = $urandom();
      lo  = $urandom();
      gap = $urandom() % 6;
      write_setting(ADDR_TIME_HI, hi);
      write_setting(ADDR_TIME_LO, lo);
      write_setting(ADDR_TIME_CTRL, 32'h0);
      @(negedge dsp_clk);
      check_time("vita_time_o", vita_time, {hi, lo});
      // Load cycle is zero, strobe cycle follows the gap
      cycles = 1;
      repeat (gap) begin
         @(posedge dsp_clk);
         cycles++;
      end
      read_word(4'd2, word);
      check_word("time low word", word, lo + 32'(cycles));
   endtask

   task automatic test_pps_load();
      logic [31:0]                hi;
      logic [31:0]                lo;
      logic [31:0]                word;
      radio_ctrl_pkg::vita_time_t pre_pulse;
      int                         waited;
      hi = $urandom();
      lo = $urandom();
      write_setting(ADDR_TIME_HI, hi);
      write_setting(ADDR_TIME_LO, lo);
      write_setting(ADDR_TIME_CTRL, 32'h1);
      @(posedge dsp_clk);
      pps <= 1'b1;
      waited = 0;
      pre_pulse = '0;
      @(negedge dsp_clk);
      while (!pps_int && waited < TIMEOUT_CYCLES) begin
         pre_pulse = vita_time;
         @(negedge dsp_clk);
         waited++;
      end
      if (!pps_int) begin
         report_failure("pps_int_o never pulsed after the PPS edge");
      end else begin
         check_time("vita_time_o at PPS", vita_time, {hi, lo});
         exp_pps_time  = pre_pulse;
         exp_good_sync = 1'b1;
         @(posedge dsp_clk);
         pps        <= 1'b0;
         // Second status pattern
         button     <= 1'b0;
         clk_status <= 1'b1;
         link_up    <= 1'b1;
         read_word(4'd3, word);
         check_word("PPS time high word", word, exp_pps_time.secs_hi);
         read_word(4'd4, word);
         check_word("PPS time low word", word, exp_pps_time.ticks_lo);
         read_word(4'd5, word);
         check_word("status word", word, status_word());
         check_leds("leds_o", leds, predict_leds());
      end
   endtask

   task automatic test_readback_stream();
      radio_ctrl_pkg::vita_time_t snap;
      snap = '0;
      // Third status pattern
      @(posedge dsp_clk);
      button     <= 1'b1;
      clk_status <= 1'b0;
      link_up    <= 1'b0;
      for (int i = 0; i <= 16; i++) begin
         @(posedge dsp_clk);
         rb_stb  <= (i < 16);
         rb_addr <= 4'(i);
         @(negedge dsp_clk);
         if (i > 0) begin
            check_word("rb_ack_o", {31'd0, rb_ack}, 32'd1);
            check_word($sformatf("rb_data_o word %0d", i - 1), rb_data,
                       expected_word(4'(i - 1), snap));
         end
         snap = vita_time;
      end
      @(negedge dsp_clk);
      check_word("rb_ack_o after last read", {31'd0, rb_ack}, 32'd0);
   endtask

   initial begin
      void'($urandom(72239));
      por_rst       = 1'b1;
      set_bus       = '0;
      pps           = 1'b0;
      run_rx        = 1'b1;
      run_tx        = 1'b0;
      clk_status    = 1'b1;
      button        = 1'b1;
      link_up       = 1'b0;
      rb_stb        = 1'b0;
      rb_addr       = '0;
      exp_led_src   = 8'h1E;
      exp_led_sw    = 8'h00;
      exp_good_sync = 1'b0;
      exp_pps_time  = '0;
      repeat (2) @(posedge dsp_clk);
      por_rst <= 1'b0;

      test_reset_values();
      test_setting_regs();
      test_led_mixing();
      test_time_load();
      test_pps_load();
      test_readback_stream();

      if (radio_ctrl_top_i.radio_ctrl_properties_i.fail_count == 0) begin
         $display("Finished with no errors");
         $finish;
      end else begin
         $display("Concurrent assertions failed on the DUT");
         $display("Finished with errors");
         $fatal(1, "Assertion failures seen");
      end
   end

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+common
common/radio_ctrl_pkg.sv
source/control_regs.sv
timekeeper/vita_time.sv
source/readback_mux.sv
source/radio_ctrl_top.sv
bench/radio_ctrl_properties.sv
bench/radio_ctrl_tb.sv

// ==== Makefile ====
# Verilator build, run and lint for the dsp_clk control slice

VERILATOR ?= verilator
TOP       ?= radio_ctrl_tb
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --assert --timescale 1ns/1ps
PASS_MSG  ?= Finished with no errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

# Pass is decided by the pass line in the simulation output
run: build
	@out="$$($(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR)
